// ==== compile.f ====
+incdir+source
source/sensor_rx_pkg.sv
source/pixel_delay_line.sv
source/sync_decoder.sv
source/roi_window.sv
source/sensor_rx_regs.sv
source/sensor_rx_top.sv
tests/sensor_rx_props.sv
tests/sensor_rx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the receiver testbench with Verilator, run it, then scan the log for the result
verilator --binary --timing -f compile.f --top-module sensor_rx_tb -o sensor_rx_sim \
	> build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/sensor_rx_sim > sim.log 2>&1
cat sim.log
grep -q "Testbench failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation PASSED"
exit 0

// ==== source/pixel_delay_line.sv ====
// Whole-cycle delay of tap+1 clocks when enabled, transparent when not; change tap only with fval low
`include "sensor_rx_settings.svh"

module pixel_delay_line (
	input  logic                  i_clk_pix,
	input  logic                  i_reset,
	input  logic                  i_delay_en,
	input  sensor_rx_pkg::tap_t   i_tap,
	input  sensor_rx_pkg::pixel_t i_pix_data,
	input  logic                  i_fval,
	input  logic                  i_lval,
	output sensor_rx_pkg::pixel_t o_pix_data,
	output logic                  o_fval,
	output logic                  o_lval
);
	import sensor_rx_pkg::*;

	localparam int DEPTH = 2 ** `TAP_WIDTH; // One stage per tap value

	pixel_t dat_sr [DEPTH];   // Pixel history, entry 0 is newest
	logic [DEPTH-1:0] fval_sr; // Frame valid history
	logic [DEPTH-1:0] lval_sr; // Line valid history

	// ----------------------------------------------------------------------
	// Shift register, one entry per pixel clock
	// ----------------------------------------------------------------------
	always_ff @(posedge i_clk_pix) begin
		if (i_reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				dat_sr[i] <= '0; // Start from a clean line
			end
			fval_sr <= '0;
			lval_sr <= '0;
		end else begin
			dat_sr[0] <= i_pix_data;
			for (int i = 1; i < DEPTH; i++) begin
				dat_sr[i] <= dat_sr[i-1];
			end
			fval_sr <= {fval_sr[DEPTH-2:0], i_fval};
			lval_sr <= {lval_sr[DEPTH-2:0], i_lval};
		end
	end

	// ----------------------------------------------------------------------
	// Tap select or bypass
	// ----------------------------------------------------------------------
	always_comb begin
		if (i_delay_en) begin
			o_pix_data = dat_sr[i_tap]; // Entry n is n+1 clocks old
			o_fval     = fval_sr[i_tap];
			o_lval     = lval_sr[i_tap];
		end else begin
			o_pix_data = i_pix_data; // Transparent, no added latency
			o_fval     = i_fval;
			o_lval     = i_lval;
		end
	end

endmodule

// ==== source/roi_window.sv ====
// Inclusive crop window with one clock latency; expects x start <= x end and y start <= y end
module roi_window (
	input  logic                  i_clk_pix,
	input  logic                  i_reset,
	input  logic                  i_crop_en,
	input  sensor_rx_pkg::coord_t i_x_start,
	input  sensor_rx_pkg::coord_t i_x_end,
	input  sensor_rx_pkg::coord_t i_y_start,
	input  sensor_rx_pkg::coord_t i_y_end,
	input  logic                  i_valid,
	input  sensor_rx_pkg::pixel_t i_pix_data,
	input  sensor_rx_pkg::coord_t i_col,
	input  sensor_rx_pkg::coord_t i_row,
	output logic                  o_pix_valid,
	output sensor_rx_pkg::pixel_t o_pix_data,
	output logic                  o_frame_start,
	output logic                  o_line_end
);

	logic in_x;       // Column inside window
	logic in_y;       // Row inside window
	logic pass;       // Pixel goes out
	logic first_pix;  // Top left corner of the output image
	logic last_col;   // Right edge of the window

	// ----------------------------------------------------------------------
	// Window compare
	// ----------------------------------------------------------------------
	assign in_x = (i_col >= i_x_start) && (i_col <= i_x_end);
	assign in_y = (i_row >= i_y_start) && (i_row <= i_y_end);
	assign pass = i_valid && (!i_crop_en || (in_x && in_y));

	// Corner moves to the window origin when cropping
	assign first_pix = i_crop_en ? (i_col == i_x_start && i_row == i_y_start)
	                             : (i_col == '0 && i_row == '0);
	assign last_col  = i_crop_en && (i_col == i_x_end); // Only marked when cropping

	// ----------------------------------------------------------------------
	// Output register
	// ----------------------------------------------------------------------
	always_ff @(posedge i_clk_pix) begin
		if (i_reset) begin
			o_pix_valid   <= 1'b0;
			o_frame_start <= 1'b0;
			o_line_end    <= 1'b0;
		end else begin
			o_pix_valid   <= pass;
			o_frame_start <= pass && first_pix;
			o_line_end    <= pass && last_col;
		end
	end

	always_ff @(posedge i_clk_pix) begin
		o_pix_data <= i_pix_data; // Qualified by o_pix_valid
	end

endmodule

// ==== source/sensor_rx_pkg.sv ====
// Types for the receiver; register layout assumes COORD_WIDTH of at most 16 bits
`include "sensor_rx_settings.svh"

package sensor_rx_pkg;

	// ----------------------------------------------------------------------
	// Data types
	// ----------------------------------------------------------------------
	typedef logic [`SENSOR_DAT_WIDTH-1:0] pixel_t; // One pixel word
	typedef logic [`COORD_WIDTH-1:0] coord_t;      // Row or column index
	typedef logic [`TAP_WIDTH-1:0] tap_t;          // Delay in pixel clocks
	typedef logic [`FRAME_CNT_WIDTH-1:0] frame_cnt_t;

	// Position of the decoder within the sensor timing
	typedef enum logic [1:0] {
		SYNC_IDLE,  // Outside a frame
		SYNC_BLANK, // In frame, between lines
		SYNC_LINE   // In a line
	} sync_state_e;

	// ----------------------------------------------------------------------
	// Register map, word aligned
	// ----------------------------------------------------------------------
	typedef enum logic [`APB_ADDR_WIDTH-1:0] {
		REG_CTRL   = 'h00, // Bit 0 delay enable, bit 1 crop enable
		REG_TAP    = 'h04, // Delay tap count
		REG_XWIN   = 'h08, // X start 11:0, x end 27:16
		REG_YWIN   = 'h0C, // Y start 11:0, y end 27:16
		REG_FRAMES = 'h10  // Frame count, read only
	} reg_addr_e;

endpackage

// ==== source/sensor_rx_regs.sv ====
// APB slave with no wait states on the pixel clock; unmapped or read-only writes flag pslverr
`include "sensor_rx_settings.svh"

module sensor_rx_regs (
	input  logic                       i_clk_pix,
	input  logic                       i_reset,
	input  logic                       i_psel,
	input  logic                       i_penable,
	input  logic                       i_pwrite,
	input  logic [`APB_ADDR_WIDTH-1:0] i_paddr,
	input  logic [31:0]                i_pwdata,
	output logic [31:0]                o_prdata,
	output logic                       o_pready,
	output logic                       o_pslverr,
	input  sensor_rx_pkg::frame_cnt_t  i_frame_count,
	output logic                       o_delay_en,
	output sensor_rx_pkg::tap_t        o_tap,
	output logic                       o_crop_en,
	output sensor_rx_pkg::coord_t      o_x_start,
	output sensor_rx_pkg::coord_t      o_x_end,
	output sensor_rx_pkg::coord_t      o_y_start,
	output sensor_rx_pkg::coord_t      o_y_end
);
	import sensor_rx_pkg::*;

	localparam int HI_LSB = 16; // Window end field offset

	reg_addr_e addr;   // Decoded address
	logic access;      // APB access phase
	logic addr_ok;     // Address is mapped
	logic wr_ro;       // Write to a read-only register
	logic wr_en;       // Accepted write

	assign addr    = reg_addr_e'(i_paddr);
	assign access  = i_psel && i_penable;
	assign wr_ro   = i_pwrite && (addr == REG_FRAMES);
	assign wr_en   = access && i_pwrite && addr_ok && !wr_ro;

	assign o_pready  = 1'b1;                         // Never stalls
	assign o_pslverr = access && (!addr_ok || wr_ro); // Access phase only

	// ----------------------------------------------------------------------
	// Read decode
	// ----------------------------------------------------------------------
	always_comb begin
		addr_ok  = 1'b1;
		o_prdata = '0;
		case (addr)
			REG_CTRL: begin
				o_prdata[0] = o_delay_en;
				o_prdata[1] = o_crop_en;
			end
			REG_TAP: o_prdata[`TAP_WIDTH-1:0] = o_tap;
			REG_XWIN: begin
				o_prdata[`COORD_WIDTH-1:0]      = o_x_start;
				o_prdata[HI_LSB +: `COORD_WIDTH] = o_x_end;
			end
			REG_YWIN: begin
				o_prdata[`COORD_WIDTH-1:0]      = o_y_start;
				o_prdata[HI_LSB +: `COORD_WIDTH] = o_y_end;
			end
			REG_FRAMES: o_prdata[`FRAME_CNT_WIDTH-1:0] = i_frame_count;
			default: addr_ok = 1'b0; // Hole or unaligned
		endcase
	end

	// ----------------------------------------------------------------------
	// Write registers, updated at the access edge
	// ----------------------------------------------------------------------
	always_ff @(posedge i_clk_pix) begin
		if (i_reset) begin
			o_delay_en <= 1'b0;
			o_crop_en  <= 1'b0;
			o_tap      <= '0;
			o_x_start  <= '0;
			o_x_end    <= '0;
			o_y_start  <= '0;
			o_y_end    <= '0;
		end else if (wr_en) begin
			case (addr)
				REG_CTRL: begin
					o_delay_en <= i_pwdata[0];
					o_crop_en  <= i_pwdata[1];
				end
				REG_TAP: o_tap <= i_pwdata[`TAP_WIDTH-1:0];
				REG_XWIN: begin
					o_x_start <= i_pwdata[`COORD_WIDTH-1:0];
					o_x_end   <= i_pwdata[HI_LSB +: `COORD_WIDTH];
				end
				REG_YWIN: begin
					o_y_start <= i_pwdata[`COORD_WIDTH-1:0];
					o_y_end   <= i_pwdata[HI_LSB +: `COORD_WIDTH];
				end
				default: ; // Read-only, already filtered
			endcase
		end
	end

endmodule

// ==== source/sensor_rx_settings.svh ====
// Widths and limits of the receiver; TAP_WIDTH also sets the delay line depth as 2**TAP_WIDTH
`ifndef SENSOR_RX_SETTINGS_SVH
`define SENSOR_RX_SETTINGS_SVH

// ----------------------------------------------------------------------
// Sensor port
// ----------------------------------------------------------------------
`define SENSOR_DAT_WIDTH 10 // Bits per pixel word
`define COORD_WIDTH 12      // Row and column counters, max 4095

// ----------------------------------------------------------------------
// Delay line and status
// ----------------------------------------------------------------------
`define TAP_WIDTH 4         // Taps 0 to 15
`define FRAME_CNT_WIDTH 16  // Frame counter, wraps

// ----------------------------------------------------------------------
// Register bus
// ----------------------------------------------------------------------
`define APB_ADDR_WIDTH 5    // Covers word addresses up to 0x1C

`endif

// ==== source/sensor_rx_top.sv ====
// Receiver top on one pixel clock; pins to o_pix_valid take tap+3 clocks, or 2 with delay off
`include "sensor_rx_settings.svh"

module sensor_rx_top (
	input  logic                       i_clk_pix,
	input  logic                       i_reset,
	input  logic                       i_psel,
	input  logic                       i_penable,
	input  logic                       i_pwrite,
	input  logic [`APB_ADDR_WIDTH-1:0] i_paddr,
	input  logic [31:0]                i_pwdata,
	output logic [31:0]                o_prdata,
	output logic                       o_pready,
	output logic                       o_pslverr,
	input  sensor_rx_pkg::pixel_t      i_pix_data,
	input  logic                       i_fval,
	input  logic                       i_lval,
	output logic                       o_pix_valid,
	output sensor_rx_pkg::pixel_t      o_pix_data,
	output logic                       o_frame_start,
	output logic                       o_line_end
);
	import sensor_rx_pkg::*;

	// ----------------------------------------------------------------------
	// Control from the register block
	// ----------------------------------------------------------------------
	logic delay_en;
	tap_t tap;
	logic crop_en;
	coord_t x_start;
	coord_t x_end;
	coord_t y_start;
	coord_t y_end;
	frame_cnt_t frame_count; // Back from the decoder

	// ----------------------------------------------------------------------
	// Pipeline links
	// ----------------------------------------------------------------------
	pixel_t dly_pix;
	logic dly_fval;
	logic dly_lval;
	logic dec_valid;
	pixel_t dec_pix;
	coord_t dec_col;
	coord_t dec_row;

	sensor_rx_regs u_sensor_rx_regs (
		.i_clk_pix(i_clk_pix), .i_reset(i_reset),
		.i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
		.i_paddr(i_paddr), .i_pwdata(i_pwdata),
		.o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
		.i_frame_count(frame_count),
		.o_delay_en(delay_en), .o_tap(tap), .o_crop_en(crop_en),
		.o_x_start(x_start), .o_x_end(x_end), .o_y_start(y_start), .o_y_end(y_end)
	);

	pixel_delay_line u_pixel_delay_line (
		.i_clk_pix(i_clk_pix), .i_reset(i_reset),
		.i_delay_en(delay_en), .i_tap(tap),
		.i_pix_data(i_pix_data), .i_fval(i_fval), .i_lval(i_lval),
		.o_pix_data(dly_pix), .o_fval(dly_fval), .o_lval(dly_lval)
	);

	// Frame end pulse is not needed downstream
	sync_decoder u_sync_decoder (
		.i_clk_pix(i_clk_pix), .i_reset(i_reset),
		.i_pix_data(dly_pix), .i_fval(dly_fval), .i_lval(dly_lval),
		.o_valid(dec_valid), .o_pix_data(dec_pix), .o_col(dec_col), .o_row(dec_row),
		.o_frame_end(), .o_frame_count(frame_count)
	);

	roi_window u_roi_window (
		.i_clk_pix(i_clk_pix), .i_reset(i_reset), .i_crop_en(crop_en),
		.i_x_start(x_start), .i_x_end(x_end), .i_y_start(y_start), .i_y_end(y_end),
		.i_valid(dec_valid), .i_pix_data(dec_pix), .i_col(dec_col), .i_row(dec_row),
		.o_pix_valid(o_pix_valid), .o_pix_data(o_pix_data),
		.o_frame_start(o_frame_start), .o_line_end(o_line_end)
	);

endmodule

// ==== source/sync_decoder.sv ====
// Position from fval and lval with one clock latency; counters wrap beyond 2**COORD_WIDTH
module sync_decoder (
	input  logic                      i_clk_pix,
	input  logic                      i_reset,
	input  sensor_rx_pkg::pixel_t     i_pix_data,
	input  logic                      i_fval,
	input  logic                      i_lval,
	output logic                      o_valid,
	output sensor_rx_pkg::pixel_t     o_pix_data,
	output sensor_rx_pkg::coord_t     o_col,
	output sensor_rx_pkg::coord_t     o_row,
	output logic                      o_frame_end,
	output sensor_rx_pkg::frame_cnt_t o_frame_count
);
	import sensor_rx_pkg::*;

	sync_state_e state;
	sync_state_e state_next;
	coord_t col_cnt;    // Next column in the current line
	coord_t row_cnt;    // Current row in the frame
	coord_t col_cur;    // Column of the incoming pixel
	logic pix_in;       // Incoming word is a pixel
	logic fval_fall;    // Frame just ended

	assign pix_in    = i_fval && i_lval;
	assign fval_fall = (state != SYNC_IDLE) && !i_fval;
	assign col_cur   = (state == SYNC_LINE) ? col_cnt : '0; // New line starts at 0

	// ----------------------------------------------------------------------
	// Sync state machine
	// ----------------------------------------------------------------------
	always_comb begin
		state_next = state;
		case (state)
			SYNC_IDLE: begin
				if (i_fval) begin
					state_next = i_lval ? SYNC_LINE : SYNC_BLANK;
				end
			end
			SYNC_BLANK: begin
				if (!i_fval) begin
					state_next = SYNC_IDLE;
				end else if (i_lval) begin
					state_next = SYNC_LINE;
				end
			end
			default: begin // SYNC_LINE
				if (!i_fval) begin
					state_next = SYNC_IDLE;
				end else if (!i_lval) begin
					state_next = SYNC_BLANK;
				end
			end
		endcase
	end

	always_ff @(posedge i_clk_pix) begin
		if (i_reset) begin
			state         <= SYNC_IDLE;
			col_cnt       <= '0;
			row_cnt       <= '0;
			o_valid       <= 1'b0;
			o_frame_end   <= 1'b0;
			o_frame_count <= '0;
		end else begin
			state       <= state_next;
			o_valid     <= pix_in;
			o_frame_end <= fval_fall; // Pulse after the last frame word
			if (pix_in) begin
				col_cnt <= col_cur + 1'b1;
			end
			if (!i_fval || state == SYNC_IDLE) begin
				row_cnt <= '0; // Held clear until fval rises
			end else if (state == SYNC_LINE && !i_lval) begin
				row_cnt <= row_cnt + 1'b1; // Falling lval
			end
			if (fval_fall) begin
				o_frame_count <= o_frame_count + 1'b1;
			end
		end
	end

	// Payload travels with o_valid
	always_ff @(posedge i_clk_pix) begin
		o_pix_data <= i_pix_data;
		o_col      <= col_cur;
		o_row      <= row_cnt;
	end

endmodule

// ==== tests/sensor_rx_props.sv ====
// Flag and APB error timing checks bound to the receiver top; assumes the top level port names
module sensor_rx_props (
	input logic i_clk_pix,
	input logic i_reset,
	input logic i_psel,
	input logic i_penable,
	input logic i_pix_valid,
	input logic i_frame_start,
	input logic i_line_end,
	input logic i_pslverr
);

	// ----------------------------------------------------------------------
	// Pixel output
	// ----------------------------------------------------------------------
	a_valid_after_reset: assert property (@(posedge i_clk_pix) i_reset |=> !i_pix_valid)
		else $error("o_pix_valid high in the cycle after reset");

	// Markers ride on a valid pixel only
	a_flags_with_valid: assert property (@(posedge i_clk_pix) disable iff (i_reset)
		(i_frame_start || i_line_end) |-> i_pix_valid)
		else $error("o_frame_start or o_line_end without o_pix_valid");

	// ----------------------------------------------------------------------
	// APB
	// ----------------------------------------------------------------------
	a_slverr_in_access: assert property (@(posedge i_clk_pix) disable iff (i_reset)
		i_pslverr |-> (i_psel && i_penable))
		else $error("o_pslverr outside an APB access phase");

endmodule

bind sensor_rx_top sensor_rx_props u_sensor_rx_props (
	.i_clk_pix(i_clk_pix), .i_reset(i_reset),
	.i_psel(i_psel), .i_penable(i_penable),
	.i_pix_valid(o_pix_valid), .i_frame_start(o_frame_start),
	.i_line_end(o_line_end), .i_pslverr(o_pslverr)
);

// ==== tests/sensor_rx_tb.sv ====
// Frames of 20x8 pixels with 1 to 5 blank cycles; registers change only between frames
`include "sensor_rx_settings.svh"

module sensor_rx_tb;
	import sensor_rx_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int FRAME_W = 20;
	localparam int FRAME_H = 8;
	localparam int BLANK_MAX = 5;
	localparam int IDLE_CYCLES = 24;  // Longer than the deepest pipeline
	localparam int NUM_FRAMES = 8;    // 2 plain, 3 delayed, 3 cropped
	localparam int FRAME_MAX_CYCLES = 2 + BLANK_MAX + FRAME_H * (FRAME_W + BLANK_MAX) + IDLE_CYCLES;
	localparam int MARGIN_CYCLES = 300; // Reset and APB traffic
	localparam int WATCHDOG_CYCLES = NUM_FRAMES * FRAME_MAX_CYCLES + MARGIN_CYCLES;

	logic clk_pix;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`APB_ADDR_WIDTH-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	pixel_t pix_data;
	logic fval;
	logic lval;
	logic pix_valid;
	pixel_t out_data;
	logic frame_start;
	logic line_end;

	logic [31:0] rng_state;
	pixel_t exp_pix_q[$];  // Expected output in order
	logic exp_fs_q[$];
	logic exp_le_q[$];
	logic cfg_delay_en;    // What the testbench programmed
	tap_t cfg_tap;
	logic cfg_crop_en;
	coord_t cfg_x_start;
	coord_t cfg_x_end;
	coord_t cfg_y_start;
	coord_t cfg_y_end;
	frame_cnt_t frames_sent;
	int seen_count = 0;
	int cycle_no = 0;
	int lat_in_cyc = 0;
	int lat_out_cyc = 0;
	bit lat_in_seen = 1'b0;
	bit lat_out_seen = 1'b0;
	logic fval_prev = 1'b0;
	tap_t tap_list [3] = '{4'd0, 4'd7, 4'd15};

	sensor_rx_top u_sensor_rx_top (
		.i_clk_pix(clk_pix), .i_reset(reset),
		.i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
		.i_paddr(paddr), .i_pwdata(pwdata),
		.o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr),
		.i_pix_data(pix_data), .i_fval(fval), .i_lval(lval),
		.o_pix_valid(pix_valid), .o_pix_data(out_data),
		.o_frame_start(frame_start), .o_line_end(line_end)
	);

	always #(CLK_PERIOD / 2) clk_pix = ~clk_pix;

	// ----------------------------------------------------------------------
	// Random numbers and reference model
	// ----------------------------------------------------------------------
	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223; // Numerical Recipes constants
		return rng_state;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		logic [31:0] r;
		r = lcg_next();
		return lo + int'(r[31:8] % 24'(hi - lo + 1)); // Low bits of an LCG are weak
	endfunction

	// Pass rule and markers for one sensor pixel
	function automatic void model_pixel(input coord_t col, input coord_t row, input pixel_t data);
		logic pass;
		logic first;
		logic last;
		if (cfg_crop_en) begin
			pass  = (col >= cfg_x_start) && (col <= cfg_x_end) &&
			        (row >= cfg_y_start) && (row <= cfg_y_end);
			first = (col == cfg_x_start) && (row == cfg_y_start);
			last  = (col == cfg_x_end);
		end else begin
			pass  = 1'b1;
			first = (col == '0) && (row == '0); // Full frame origin
			last  = 1'b0;                      // No line end without crop
		end
		if (pass) begin
			exp_pix_q.push_back(data);
			exp_fs_q.push_back(first);
			exp_le_q.push_back(last);
		end
	endfunction

	// ----------------------------------------------------------------------
	// Failure and compare tasks
	// ----------------------------------------------------------------------
	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
		if (got !== exp) fail_run($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) fail_run($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_frames(input string name, input frame_cnt_t got, input frame_cnt_t exp);
		if (got !== exp) fail_run($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_rdata(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) fail_run($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_latency(input int got, input int exp);
		if (got != exp) fail_run($sformatf("ERROR: latency got 0x%h expected 0x%h", got, exp));
	endtask

	// ----------------------------------------------------------------------
	// APB master with one setup and one access cycle
	// ----------------------------------------------------------------------
	task automatic apb_write(input logic [`APB_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
	                         input logic exp_err);
		@(negedge clk_pix);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(negedge clk_pix);
		penable = 1'b1;
		@(posedge clk_pix); // Access edge
		check_flag("o_pready", pready, 1'b1);
		check_flag("o_pslverr", pslverr, exp_err);
		@(negedge clk_pix);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [`APB_ADDR_WIDTH-1:0] addr, output logic [31:0] data,
	                        input logic exp_err);
		@(negedge clk_pix);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(negedge clk_pix);
		penable = 1'b1;
		@(posedge clk_pix);
		data = prdata;
		check_flag("o_pready", pready, 1'b1);
		check_flag("o_pslverr", pslverr, exp_err);
		@(negedge clk_pix);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic read_expect(input string name, input logic [`APB_ADDR_WIDTH-1:0] addr,
	                           input logic [31:0] exp);
		logic [31:0] rd;
		apb_read(addr, rd, 1'b0);
		check_rdata(name, rd, exp);
	endtask

	task automatic check_frame_count();
		logic [31:0] rd;
		apb_read(REG_FRAMES, rd, 1'b0);
		check_frames("REG_FRAMES", frame_cnt_t'(rd), frames_sent);
	endtask

	task automatic set_ctrl(input logic delay_en, input logic crop_en, input tap_t tap);
		cfg_delay_en = delay_en;
		cfg_crop_en  = crop_en;
		cfg_tap      = tap;
		apb_write(REG_TAP, 32'(tap), 1'b0);
		apb_write(REG_CTRL, {30'h0, crop_en, delay_en}, 1'b0);
	endtask

	// Random window that stays inside the frame
	task automatic set_window();
		int xs;
		int ys;
		xs = rand_range(0, FRAME_W - 1);
		ys = rand_range(0, FRAME_H - 1);
		cfg_x_start = coord_t'(xs);
		cfg_x_end   = coord_t'(xs + rand_range(0, FRAME_W - 1 - xs));
		cfg_y_start = coord_t'(ys);
		cfg_y_end   = coord_t'(ys + rand_range(0, FRAME_H - 1 - ys));
		apb_write(REG_XWIN, {4'h0, cfg_x_end, 4'h0, cfg_x_start}, 1'b0);
		apb_write(REG_YWIN, {4'h0, cfg_y_end, 4'h0, cfg_y_start}, 1'b0);
	endtask

	// ----------------------------------------------------------------------
	// Sensor frame followed by idle until the pipeline drains
	// ----------------------------------------------------------------------
	task automatic run_frame();
		@(negedge clk_pix);
		fval = 1'b1;
		lval = 1'b0;
		repeat (rand_range(1, BLANK_MAX)) @(negedge clk_pix); // Leading blank
		for (int r = 0; r < FRAME_H; r++) begin
			for (int c = 0; c < FRAME_W; c++) begin
				pix_data = pixel_t'(lcg_next() >> 8);
				lval     = 1'b1;
				model_pixel(coord_t'(c), coord_t'(r), pix_data);
				@(negedge clk_pix);
			end
			lval = 1'b0;
			repeat (rand_range(1, BLANK_MAX)) @(negedge clk_pix);
		end
		fval     = 1'b0;
		pix_data = '0;
		repeat (IDLE_CYCLES) @(negedge clk_pix);
		frames_sent = frames_sent + 1'b1;
		if (!cfg_crop_en) begin
			if (!lat_out_seen) fail_run("No output pixel followed the first line of the frame");
			check_latency(lat_out_cyc - lat_in_cyc, cfg_delay_en ? int'(cfg_tap) + 3 : 2);
		end
	endtask

	// Clock edges from the first in-line pixel to the first o_pix_valid
	always @(posedge clk_pix) begin
		cycle_no = cycle_no + 1;
		if (fval && !fval_prev) begin
			lat_in_seen  = 1'b0;
			lat_out_seen = 1'b0;
		end
		if (fval && lval && !lat_in_seen) begin
			lat_in_seen = 1'b1;
			lat_in_cyc  = cycle_no;
		end
		if (lat_in_seen && !lat_out_seen && pix_valid === 1'b1) begin
			lat_out_seen = 1'b1;
			lat_out_cyc  = cycle_no;
		end
		fval_prev = fval;
	end

	// Output checker
	always @(posedge clk_pix) begin
		if (!reset && pix_valid === 1'b1) begin
			if (exp_pix_q.size() == 0) begin
				fail_run("A pixel came out while no pixel was expected");
			end else begin
				check_pixel("o_pix_data", out_data, exp_pix_q.pop_front());
				check_flag("o_frame_start", frame_start, exp_fs_q.pop_front());
				check_flag("o_line_end", line_end, exp_le_q.pop_front());
				seen_count = seen_count + 1;
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		fail_run($sformatf("Timeout: the run did not end within %0d clock cycles",
		                   WATCHDOG_CYCLES));
	end

	// ----------------------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------------------
	initial begin
		clk_pix      = 1'b0;
		reset        = 1'b1;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = '0;
		pwdata       = '0;
		pix_data     = '0;
		fval         = 1'b0;
		lval         = 1'b0;
		rng_state    = 32'h78e4;
		cfg_delay_en = 1'b0;
		cfg_tap      = '0;
		cfg_crop_en  = 1'b0;
		cfg_x_start  = '0;
		cfg_x_end    = '0;
		cfg_y_start  = '0;
		cfg_y_end    = '0;
		frames_sent  = '0;
		repeat (2) @(negedge clk_pix);
		reset = 1'b0;

		// Readback and bus errors
		apb_write(REG_CTRL, 32'h0000_0003, 1'b0);
		read_expect("REG_CTRL", REG_CTRL, 32'h0000_0003);
		apb_write(REG_TAP, 32'h0000_000a, 1'b0);
		read_expect("REG_TAP", REG_TAP, 32'h0000_000a);
		apb_write(REG_XWIN, 32'h0013_0005, 1'b0);
		read_expect("REG_XWIN", REG_XWIN, 32'h0013_0005);
		apb_write(REG_YWIN, 32'h0007_0002, 1'b0);
		read_expect("REG_YWIN", REG_YWIN, 32'h0007_0002);
		apb_write(5'h14, 32'h0000_0000, 1'b1);       // Hole in the map
		apb_write(5'h02, 32'h0000_0000, 1'b1);       // Unaligned
		apb_write(REG_FRAMES, 32'h0000_1234, 1'b1);  // Read only
		apb_read(5'h1c, pwdata, 1'b1);
		pwdata = '0;
		check_frame_count();
		read_expect("REG_CTRL", REG_CTRL, 32'h0000_0003);
		read_expect("REG_TAP", REG_TAP, 32'h0000_000a);
		read_expect("REG_XWIN", REG_XWIN, 32'h0013_0005);
		read_expect("REG_YWIN", REG_YWIN, 32'h0007_0002);

		// Delay and crop off
		set_ctrl(1'b0, 1'b0, 4'd0);
		repeat (2) run_frame();
		check_frame_count();

		// Delay on at several taps
		foreach (tap_list[i]) begin
			set_ctrl(1'b1, 1'b0, tap_list[i]);
			run_frame();
		end

		// Random crop windows with the last one also delayed
		for (int i = 0; i < 3; i++) begin
			set_window();
			set_ctrl(i == 2, 1'b1, cfg_tap);
			run_frame();
		end
		check_frame_count();

		if (exp_pix_q.size() == 0 && seen_count > 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			fail_run("Expected pixels were still missing at the end of the run");
		end
	end

endmodule
